//--- design/piano_note_pkg.sv
// Note and song position types
// Shared by the song ROM, the counters and the note checker

package piano_note_pkg;

    // Pitch index within one octave, 0 to 11
    typedef logic [3:0] note_t;

    // Song position, also used as the round number
    typedef logic [3:0] addr_t;

    // Keys on the keyboard
    localparam int NOTE_COUNT = 12;

endpackage

//--- design/piano_ctrl_pkg.sv
// Lesson control types
// State encoding of the lesson FSM and the timer count width

package piano_ctrl_pkg;

    // Timer count in clock cycles
    typedef logic [7:0] tick_t;

    // ------------------------------------------------------------
    // Lesson FSM states
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        st_idle,
        st_init_round,
        st_show_note,
        st_show_gap,
        st_reply_wait,
        st_reply_check,
        st_next_note,
        st_next_round,
        st_won,
        st_lost
    } lesson_state_t;

endpackage

//--- design/song_rom.sv
// Song ROM
// Fixed melody table, note at address i is (5*i + 3) mod 12
`timescale 1ns/1ns

module song_rom (
    input  piano_note_pkg::addr_t addr,
    output piano_note_pkg::note_t note
);
    import piano_note_pkg::*;

    note_t table_note;

    always_comb begin
        case (addr)
            4'd0:    table_note = 4'd3;
            4'd1:    table_note = 4'd8;
            4'd2:    table_note = 4'd1;
            4'd3:    table_note = 4'd6;
            4'd4:    table_note = 4'd11;
            4'd5:    table_note = 4'd4;
            4'd6:    table_note = 4'd9;
            4'd7:    table_note = 4'd2;
            4'd8:    table_note = 4'd7;
            4'd9:    table_note = 4'd0;
            4'd10:   table_note = 4'd5;
            4'd11:   table_note = 4'd10;
            4'd12:   table_note = 4'd3;
            4'd13:   table_note = 4'd8;
            4'd14:   table_note = 4'd1;
            default: table_note = 4'd6;
        endcase
    end

    // Keep the output on a real key
    assign note = (table_note < NOTE_COUNT) ? table_note : '0;

endmodule

//--- design/lesson_counters.sv
// Lesson counters
// Note address within a round and round number, with their end flags
`timescale 1ns/1ns

module lesson_counters #(
    parameter int SONG_LENGTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  addr_clear,
    input  logic                  addr_step,
    input  logic                  round_clear,
    input  logic                  round_step,
    output piano_note_pkg::addr_t addr,
    output piano_note_pkg::addr_t round,
    output logic                  last_in_round,
    output logic                  last_round
);
    import piano_note_pkg::*;

    // Round 16 wraps to 0 in four bits and the compare wraps with it
    localparam addr_t LAST_ROUND = addr_t'(SONG_LENGTH);

    addr_t round_prev;

    assign round_prev    = round - addr_t'(1);
    assign last_in_round = (addr == round_prev);
    assign last_round    = (round == LAST_ROUND);

    // Note address
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr <= '0;
        end else if (addr_clear) begin
            addr <= '0;
        end else if (addr_step) begin
            // Back to the first note once the round is exhausted
            if (last_in_round) begin
                addr <= '0;
            end else begin
                addr <= addr + addr_t'(1);
            end
        end
    end

    // Round number, 0 only until the first start
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round <= '0;
        end else if (round_clear) begin
            round <= addr_t'(1);
        end else if (round_step) begin
            round <= round + addr_t'(1);
        end
    end

endmodule

//--- design/beat_timer.sv
// Beat timer
// Down-counter for note display time and the player's reply window
`timescale 1ns/1ns

module beat_timer #(
    parameter int SHOW_TICKS  = 4,
    parameter int REPLY_TICKS = 20
) (
    input  logic clock,
    input  logic reset,
    input  logic load_show,
    input  logic load_reply,
    output logic expired
);
    import piano_ctrl_pkg::*;

    // The load cycle counts as the first tick of the interval
    localparam tick_t SHOW_LOAD  = tick_t'(SHOW_TICKS - 1);
    localparam tick_t REPLY_LOAD = tick_t'(REPLY_TICKS - 1);

    tick_t count;

    // ------------------------------------------------------------
    // Count down and park at zero
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (load_reply) begin
            count <= REPLY_LOAD;
        end else if (load_show) begin
            count <= SHOW_LOAD;
        end else if (count != '0) begin
            count <= count - tick_t'(1);
        end
    end

    assign expired = (count == '0);

endmodule

//--- design/note_checker.sv
// Note checker
// Registers an accepted key press and its match against the expected note
`timescale 1ns/1ns

module note_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  accept,
    input  logic                  key_valid,
    input  piano_note_pkg::note_t key_note,
    input  piano_note_pkg::note_t expected_note,
    output logic                  key_seen,
    output logic                  key_match
);

    logic press;

    // Presses outside the player's turn are dropped here
    assign press = accept & key_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            key_seen  <= 1'b0;
            key_match <= 1'b0;
        end else begin
            key_seen <= press;
            if (press) begin
                key_match <= (key_note == expected_note);
            end else if (!accept) begin
                // Cleared outside the turn, so a timeout never sees an old match
                key_match <= 1'b0;
            end
        end
    end

endmodule

//--- design/lesson_control.sv
// Lesson control unit
// Moore FSM that shows each round, waits for the replies and reports win or loss
`timescale 1ns/1ns

module lesson_control (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic retry,
    input  logic last_in_round,
    input  logic last_round,
    input  logic expired,
    input  logic key_seen,
    input  logic key_match,
    output logic addr_clear,
    output logic addr_step,
    output logic round_clear,
    output logic round_step,
    output logic load_show,
    output logic load_reply,
    output logic accept,
    output logic show_active,
    output logic player_turn,
    output logic won,
    output logic lost
);
    import piano_ctrl_pkg::*;

    lesson_state_t state;
    lesson_state_t state_next;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_init_round;
                end
            end
            st_init_round: begin
                state_next = st_show_note;
            end
            st_show_note: begin
                // Last note shown, hand over to the player
                if (expired) begin
                    state_next = last_in_round ? st_next_note : st_show_gap;
                end
            end
            st_show_gap: begin
                state_next = st_show_note;
            end
            st_next_note: begin
                state_next = st_reply_wait;
            end
            st_reply_wait: begin
                // On timeout a press in the final cycle is still judged
                if (key_seen || expired) begin
                    state_next = st_reply_check;
                end
            end
            st_reply_check: begin
                if (!key_match) begin
                    state_next = st_lost;
                end else if (!last_in_round) begin
                    state_next = st_next_note;
                end else if (last_round) begin
                    state_next = st_won;
                end else begin
                    state_next = st_next_round;
                end
            end
            st_next_round: begin
                state_next = st_show_note;
            end
            st_won: begin
                if (start) begin
                    state_next = st_init_round;
                end
            end
            st_lost: begin
                if (start) begin
                    state_next = st_init_round;
                end else if (retry) begin
                    // Address and show time are already set up in this state
                    state_next = st_show_note;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Outputs, decoded from the state only
    // ------------------------------------------------------------
    assign round_clear = (state == st_init_round);
    assign round_step  = (state == st_next_round);

    assign addr_clear = (state == st_init_round) || (state == st_next_round)
                     || (state == st_lost);
    // Stepping past the last note wraps the address for the reply
    assign addr_step  = (state == st_show_gap) || (state == st_next_note);

    assign load_show  = (state == st_init_round) || (state == st_show_gap)
                     || (state == st_next_round) || (state == st_lost);
    assign load_reply = (state == st_next_note);

    assign show_active = (state == st_show_note);
    assign player_turn = (state == st_reply_wait);
    assign accept      = (state == st_reply_wait);

    assign won  = (state == st_won);
    assign lost = (state == st_lost);

endmodule

//--- design/piano_lesson_top.sv
// Piano lesson top level
// Repeat-the-melody game core built from the control unit and its datapath
`timescale 1ns/1ns

module piano_lesson_top #(
    parameter int SONG_LENGTH = 8,
    parameter int SHOW_TICKS  = 4,
    parameter int REPLY_TICKS = 20
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  retry,
    input  logic                  key_valid,
    input  piano_note_pkg::note_t key_note,
    output logic                  show_active,
    output piano_note_pkg::note_t show_note,
    output logic                  player_turn,
    output piano_note_pkg::addr_t round,
    output logic                  won,
    output logic                  lost
);
    import piano_note_pkg::*;

    addr_t addr;
    logic  last_in_round;
    logic  last_round;
    logic  expired;
    logic  key_seen;
    logic  key_match;
    logic  addr_clear;
    logic  addr_step;
    logic  round_clear;
    logic  round_step;
    logic  load_show;
    logic  load_reply;
    logic  accept;

    // ROM output is both the shown note and the expected reply
    song_rom i_song_rom (
        .addr (addr),
        .note (show_note)
    );

    lesson_counters #(
        .SONG_LENGTH (SONG_LENGTH)
    ) i_lesson_counters (
        .clock         (clock),
        .reset         (reset),
        .addr_clear    (addr_clear),
        .addr_step     (addr_step),
        .round_clear   (round_clear),
        .round_step    (round_step),
        .addr          (addr),
        .round         (round),
        .last_in_round (last_in_round),
        .last_round    (last_round)
    );

    beat_timer #(
        .SHOW_TICKS  (SHOW_TICKS),
        .REPLY_TICKS (REPLY_TICKS)
    ) i_beat_timer (
        .clock      (clock),
        .reset      (reset),
        .load_show  (load_show),
        .load_reply (load_reply),
        .expired    (expired)
    );

    note_checker i_note_checker (
        .clock         (clock),
        .reset         (reset),
        .accept        (accept),
        .key_valid     (key_valid),
        .key_note      (key_note),
        .expected_note (show_note),
        .key_seen      (key_seen),
        .key_match     (key_match)
    );

    lesson_control i_lesson_control (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .retry         (retry),
        .last_in_round (last_in_round),
        .last_round    (last_round),
        .expired       (expired),
        .key_seen      (key_seen),
        .key_match     (key_match),
        .addr_clear    (addr_clear),
        .addr_step     (addr_step),
        .round_clear   (round_clear),
        .round_step    (round_step),
        .load_show     (load_show),
        .load_reply    (load_reply),
        .accept        (accept),
        .show_active   (show_active),
        .player_turn   (player_turn),
        .won           (won),
        .lost          (lost)
    );

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset
// Free-running clock with reset held high for the first cycles
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

//--- testbench/piano_lesson_sva.sv
// Lesson control assertions
// Result exclusivity and loss-state checks, bound to the control unit
`timescale 1ns/1ns

module piano_lesson_sva (
    input logic                          clock,
    input logic                          reset,
    input piano_ctrl_pkg::lesson_state_t state,
    input logic                          load_reply,
    input logic                          show_active,
    input logic                          player_turn,
    input logic                          won,
    input logic                          lost
);
    import piano_ctrl_pkg::*;

    // A game ends in one result only
    result_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(won && lost)
    ) else $error("won and lost are high in the same cycle");

    // Show and reply phases never overlap
    phase_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(show_active && player_turn)
    ) else $error("show_active and player_turn are high in the same cycle");

    // No reply window opens after a loss
    lost_no_window: assert property (
        @(posedge clock) disable iff (reset) (state == st_lost) |-> !load_reply
    ) else $error("load_reply raised in the lost state");

endmodule

//--- testbench/piano_lesson_tb.sv
// Piano lesson testbench
// Plays the song against the game core and checks shows, replies and results
`timescale 1ns/1ns

module piano_lesson_tb;
    import piano_note_pkg::*;

    localparam int SONG_LENGTH = 4;
    localparam int SHOW_TICKS  = 4;
    localparam int REPLY_TICKS = 20;
    localparam int WATCHDOG_CYCLES =
        SONG_LENGTH * SONG_LENGTH * (SHOW_TICKS + REPLY_TICKS + 10) * 6;
    // Longest wait for the turn, a full show of the last round
    localparam int TURN_LIMIT = SONG_LENGTH * (SHOW_TICKS + 1) + 8;

    // Output selectors for wait_for
    localparam int SEL_SHOW = 0;
    localparam int SEL_TURN = 1;
    localparam int SEL_WON  = 2;
    localparam int SEL_LOST = 3;

    logic        clock;
    logic        reset;
    logic        start;
    logic        retry;
    logic        key_valid;
    note_t       key_note;
    logic        show_active;
    note_t       show_note;
    logic        player_turn;
    addr_t       round;
    logic        won;
    logic        lost;

    logic [31:0] lfsr_state;
    string       test_name;
    int          show_total;
    int          show_base;
    int          show_len;
    logic        show_seen;

    tb_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (2)
    ) i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    piano_lesson_top #(
        .SONG_LENGTH (SONG_LENGTH),
        .SHOW_TICKS  (SHOW_TICKS),
        .REPLY_TICKS (REPLY_TICKS)
    ) i_dut (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .retry       (retry),
        .key_valid   (key_valid),
        .key_note    (key_note),
        .show_active (show_active),
        .show_note   (show_note),
        .player_turn (player_turn),
        .round       (round),
        .won         (won),
        .lost        (lost)
    );

    bind lesson_control piano_lesson_sva i_sva (.*);

    // ------------------------------------------------------------
    // Reference model and random source
    // ------------------------------------------------------------
    function automatic note_t expected_note(input int index);
        return note_t'((5 * index + 3) % NOTE_COUNT);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'h8020_0003;
        end
        return value >> 1;
    endfunction

    task automatic random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_note(input string name, input note_t expected, input note_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected note %0d, actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1, "note check");
        end
    endtask

    task automatic check_round(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected round %0d, actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1, "round check");
        end
    endtask

    task automatic check_flag(input string name, input bit expected, input bit actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0b, actual %0b", name, expected, actual);
            $display("Something failed");
            $fatal(1, "flag check");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1, "count check");
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic bit output_level(input int sel);
        case (sel)
            SEL_SHOW: return show_active;
            SEL_TURN: return player_turn;
            SEL_WON:  return won;
            default:  return lost;
        endcase
    endfunction

    function automatic string output_name(input int sel);
        case (sel)
            SEL_SHOW: return "show_active";
            SEL_TURN: return "player_turn";
            SEL_WON:  return "won";
            default:  return "lost";
        endcase
    endfunction

    // Sampled on the falling edge, away from the DUT updates
    task automatic wait_for(input string name, input int sel, input bit level, input int limit);
        int count;
        count = 0;
        do begin
            @(negedge clock);
            count++;
        end while (output_level(sel) != level && count < limit);
        if (output_level(sel) != level) begin
            $display("%s: %s did not go %s within %0d cycles", name, output_name(sel),
                     level ? "high" : "low", limit);
            $display("Something failed");
            $fatal(1, "wait limit");
        end
    endtask

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic pulse_retry();
        @(posedge clock);
        retry <= 1'b1;
        @(posedge clock);
        retry <= 1'b0;
    endtask

    task automatic press_key(input note_t note, input int delay);
        repeat (delay) @(negedge clock);
        @(posedge clock);
        key_valid <= 1'b1;
        key_note  <= note;
        @(posedge clock);
        key_valid <= 1'b0;
    endtask

    // Turn start also closes the count of notes shown since the last turn
    task automatic wait_turn(input int r, input int shows);
        wait_for(test_name, SEL_TURN, 1'b1, TURN_LIMIT);
        check_count({test_name, " show count"}, shows, show_total - show_base);
        show_base = show_total;
        check_round(test_name, addr_t'(r), round);
        check_flag({test_name, " show_active"}, 1'b0, show_active);
    endtask

    // Replies to round r, with a wrong note at wrong_at when it is in range
    task automatic play_round(input int r, input int wrong_at);
        int    delay;
        int    pick;
        note_t good;
        note_t bad;
        bit    failed;
        failed = 1'b0;
        for (int i = 0; i < r && !failed; i++) begin
            wait_turn(r, (i == 0) ? r : 0);
            good = expected_note(i);
            random_bits(5, delay);
            delay = delay % (REPLY_TICKS - 2);
            if (i == wrong_at) begin
                random_bits(4, pick);
                bad = note_t'((int'(good) + 1 + pick % (NOTE_COUNT - 1)) % NOTE_COUNT);
                press_key(bad, delay);
                wait_for(test_name, SEL_LOST, 1'b1, 4);
                check_flag({test_name, " player_turn"}, 1'b0, player_turn);
                check_flag({test_name, " won"}, 1'b0, won);
                check_round(test_name, addr_t'(r), round);
                failed = 1'b1;
            end else begin
                press_key(good, delay);
                if (i < r - 1) begin
                    wait_for(test_name, SEL_TURN, 1'b0, 4);
                end else if (r == SONG_LENGTH) begin
                    wait_for(test_name, SEL_WON, 1'b1, 4);
                end else begin
                    wait_for(test_name, SEL_SHOW, 1'b1, 4);
                end
                check_flag({test_name, " lost"}, 1'b0, lost);
            end
        end
    endtask

    task automatic let_time_out(input int r);
        wait_turn(r, r);
        wait_for(test_name, SEL_LOST, 1'b1, REPLY_TICKS + 5);
        check_flag({test_name, " player_turn"}, 1'b0, player_turn);
        check_flag({test_name, " won"}, 1'b0, won);
        check_round(test_name, addr_t'(r), round);
    endtask

    // Back-to-back key pulses in the middle of one show
    task automatic press_during_show(input int count);
        int pick;
        wait_for(test_name, SEL_SHOW, 1'b1, TURN_LIMIT);
        for (int i = 0; i < count; i++) begin
            random_bits(4, pick);
            @(posedge clock);
            key_valid <= 1'b1;
            key_note  <= note_t'(pick % NOTE_COUNT);
        end
        @(posedge clock);
        key_valid <= 1'b0;
        @(negedge clock);
        check_flag({test_name, " show_active"}, 1'b1, show_active);
        check_flag({test_name, " player_turn"}, 1'b0, player_turn);
    endtask

    // ------------------------------------------------------------
    // Show monitor, compares every shown note and its length
    // ------------------------------------------------------------
    always @(negedge clock) begin
        if (!reset) begin
            if (show_active && !show_seen) begin
                check_note(test_name, expected_note(show_total - show_base), show_note);
                show_len = 1;
            end else if (show_active) begin
                show_len = show_len + 1;
            end else if (show_seen) begin
                check_count({test_name, " show length"}, SHOW_TICKS, show_len);
                show_total = show_total + 1;
            end
            show_seen = show_active;
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog ran out after %0d cycles, the game core hangs", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1, "watchdog");
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        start      = 1'b0;
        retry      = 1'b0;
        key_valid  = 1'b0;
        key_note   = '0;
        lfsr_state = 32'h13ba;
        test_name  = "reset";
        show_total = 0;
        show_base  = 0;
        show_len   = 0;
        show_seen  = 1'b0;

        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        check_round(test_name, addr_t'(0), round);
        check_flag({test_name, " show_active"}, 1'b0, show_active);
        check_flag({test_name, " player_turn"}, 1'b0, player_turn);
        check_flag({test_name, " won"}, 1'b0, won);
        check_flag({test_name, " lost"}, 1'b0, lost);

        // Every round shown and answered
        test_name = "full win";
        pulse_start();
        for (int r = 1; r <= SONG_LENGTH; r++) begin
            play_round(r, -1);
        end
        check_flag({test_name, " won"}, 1'b1, won);
        check_flag({test_name, " lost"}, 1'b0, lost);

        test_name = "wrong note";
        pulse_start();
        play_round(1, -1);
        play_round(2, 1);

        // Same round again after the loss
        test_name = "retry";
        pulse_retry();
        play_round(2, -1);

        test_name = "timeout";
        let_time_out(3);

        test_name = "restart with ignored presses";
        pulse_start();
        press_during_show(2);
        play_round(1, -1);
        check_flag({test_name, " won"}, 1'b0, won);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- files.f
design/piano_note_pkg.sv
design/piano_ctrl_pkg.sv
design/song_rom.sv
design/lesson_counters.sv
design/beat_timer.sv
design/note_checker.sv
design/lesson_control.sv
design/piano_lesson_top.sv
testbench/tb_clock_gen.sv
testbench/piano_lesson_sva.sv
testbench/piano_lesson_tb.sv

//--- Makefile
TOP = piano_lesson_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
